//--- bench/overlay_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module overlay_tb;

    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_COUNT   = 2000;
    localparam int TIMEOUT_CYCLES = 10000;     // sweeps 4400 + random 2000 + reset plus slack
    localparam int LABEL_Y        = `OVL_LABEL_Y;
    localparam int LABEL_H        = `OVL_LABEL_H;
    localparam int FREQ_X         = `OVL_FREQ_X;
    localparam int FREQ_W         = `OVL_FREQ_W;
    localparam int VPP_X          = `OVL_VPP_X;
    localparam int VPP_W          = `OVL_VPP_W;
    localparam int GLYPH_X        = `OVL_GLYPH_X;
    localparam int GLYPH_SIZE     = `OVL_GLYPH_SIZE;
    localparam int GLYPH0_Y       = `OVL_GLYPH0_Y;
    localparam int GLYPH1_Y       = `OVL_GLYPH1_Y;

    // window origins and sizes for the random phase
    localparam int WIN_X [4] = '{FREQ_X, VPP_X, GLYPH_X, GLYPH_X};
    localparam int WIN_Y [4] = '{LABEL_Y, LABEL_Y, GLYPH0_Y, GLYPH1_Y};
    localparam int WIN_W [4] = '{FREQ_W, VPP_W, GLYPH_SIZE, GLYPH_SIZE};
    localparam int WIN_H [4] = '{LABEL_H, LABEL_H, GLYPH_SIZE, GLYPH_SIZE};

    typedef struct packed {
        logic ink;                              // white seen
        logic back;                             // window background seen
    } colour_seen_t;

    logic                    lcd_pclk;
    logic                    rst_n;
    overlay_pkg::pix_pos_t   pixel_pos;
    logic                    back_en;
    logic [`OVL_COLOR_W-1:0] pixel_data;

    integer                  seed;
    logic                    in_random;
    int                      cycle_cnt   = 0;
    logic                    rst_q       = 1'b0;
    overlay_pkg::pix_pos_t   prev_pos    = '0;
    overlay_pkg::region_e    cur_region;
    overlay_pkg::region_e    prev_region;
    int                      prev_row;
    logic                    exp_back_en;
    colour_seen_t            freq_seen   = '0;
    colour_seen_t            vpp_seen    = '0;
    colour_seen_t            glyph0_seen = '0;
    colour_seen_t            glyph1_seen = '0;
    logic                    jump_seen   = 1'b0;

    overlay_top u_dut (
        .lcd_pclk   (lcd_pclk),
        .rst_n      (rst_n),
        .pixel_pos  (pixel_pos),
        .back_en    (back_en),
        .pixel_data (pixel_data)
    );

    initial begin
        lcd_pclk = 1'b0;
        forever #10 lcd_pclk = ~lcd_pclk;       // 50 MHz
    end

    // ******************************
    // reference window rule
    // ******************************
    function automatic bit in_span(input int v, input int start, input int len);
        return (v >= start) && (v < start + len);
    endfunction

    // x windows lead by one pixel
    function automatic overlay_pkg::region_e region_of(input int x, input int y);
        overlay_pkg::region_e r;
        r = overlay_pkg::none;
        if (in_span(y, LABEL_Y, LABEL_H) && in_span(x, FREQ_X - 1, FREQ_W)) begin
            r = overlay_pkg::label_freq;
        end else if (in_span(y, LABEL_Y, LABEL_H) && in_span(x, VPP_X - 1, VPP_W)) begin
            r = overlay_pkg::label_vpp;
        end else if (in_span(x, GLYPH_X - 1, GLYPH_SIZE) && in_span(y, GLYPH0_Y, GLYPH_SIZE)) begin
            r = overlay_pkg::glyph_0;
        end else if (in_span(x, GLYPH_X - 1, GLYPH_SIZE) && in_span(y, GLYPH1_Y, GLYPH_SIZE)) begin
            r = overlay_pkg::glyph_1;
        end
        return r;
    endfunction

    function automatic bit is_glyph(input overlay_pkg::region_e r);
        return (r == overlay_pkg::glyph_0) || (r == overlay_pkg::glyph_1);
    endfunction

    function automatic bit is_label(input overlay_pkg::region_e r);
        return (r == overlay_pkg::label_freq) || (r == overlay_pkg::label_vpp);
    endfunction

    function automatic colour_seen_t note_colour(input colour_seen_t s,
                                                 input logic [`OVL_COLOR_W-1:0] back);
        colour_seen_t n;
        n = s;
        if (pixel_data == `OVL_INK_COLOR) n.ink = 1'b1;
        if (pixel_data == back) n.back = 1'b1;
        return n;
    endfunction

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    always_comb begin
        cur_region  = region_of(int'(pixel_pos.x), int'(pixel_pos.y));
        prev_region = region_of(int'(prev_pos.x), int'(prev_pos.y));
        exp_back_en = (cur_region != overlay_pkg::none);
        prev_row    = (prev_region == overlay_pkg::glyph_1) ? int'(prev_pos.y) - GLYPH1_Y
                                                            : int'(prev_pos.y) - GLYPH0_Y;
    end

    always @(posedge lcd_pclk) begin
        prev_pos <= pixel_pos;                  // coordinate behind pixel_data
        rst_q    <= rst_n;
    end

    // ******************************
    // failure and timeout
    // ******************************
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_failed(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    always @(posedge lcd_pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run still going after %0d clock cycles", cycle_cnt));
        end
    end

    // ******************************
    // checking assertions
    // ******************************
    a_reset_green : assert property (@(posedge lcd_pclk)
        (cycle_cnt != 0 && (!rst_n || !rst_q)) |-> (pixel_data == `OVL_BACK_COLOR))
        else check_failed($sformatf("pixel_data %h not green around reset", pixel_data));

    a_back_en_rule : assert property (@(posedge lcd_pclk) back_en == exp_back_en)
        else check_failed($sformatf("back_en %b at x %0d y %0d", back_en,
                                    pixel_pos.x, pixel_pos.y));

    a_outside_green : assert property (@(posedge lcd_pclk)
        (rst_n && rst_q && prev_region == overlay_pkg::none)
            |-> (pixel_data == `OVL_BACK_COLOR))
        else check_failed($sformatf("outside pixel gave %h", pixel_data));

    a_label_colour : assert property (@(posedge lcd_pclk)
        (rst_n && rst_q && is_label(prev_region))
            |-> (pixel_data == `OVL_INK_COLOR || pixel_data == `OVL_BACK_COLOR))
        else check_failed($sformatf("label pixel gave %h", pixel_data));

    a_glyph_colour : assert property (@(posedge lcd_pclk)
        (rst_n && rst_q && is_glyph(prev_region))
            |-> (pixel_data == `OVL_INK_COLOR || pixel_data == `OVL_GLYPH_BACK))
        else check_failed($sformatf("glyph pixel gave %h", pixel_data));

    a_glyph_top_black : assert property (@(posedge lcd_pclk)
        (rst_n && rst_q && is_glyph(prev_region) && prev_row < 2)
            |-> (pixel_data == `OVL_GLYPH_BACK))
        else check_failed($sformatf("glyph row %0d gave %h", prev_row, pixel_data));

    // both colours per window and window-to-window jumps in the random phase
    always @(posedge lcd_pclk) begin
        if (rst_n && rst_q) begin
            case (prev_region)
                overlay_pkg::label_freq: freq_seen   <= note_colour(freq_seen, `OVL_BACK_COLOR);
                overlay_pkg::label_vpp:  vpp_seen    <= note_colour(vpp_seen, `OVL_BACK_COLOR);
                overlay_pkg::glyph_0:    glyph0_seen <= note_colour(glyph0_seen, `OVL_GLYPH_BACK);
                overlay_pkg::glyph_1:    glyph1_seen <= note_colour(glyph1_seen, `OVL_GLYPH_BACK);
                default:                 ;
            endcase
            if (in_random && prev_region != overlay_pkg::none
                && cur_region != overlay_pkg::none && cur_region != prev_region) begin
                jump_seen <= 1'b1;
            end
        end
    end

    // ******************************
    // stimulus
    // ******************************
    task automatic drive_pos(input int x, input int y);
        @(posedge lcd_pclk);
        pixel_pos.x <= `OVL_COORD_W'(x);
        pixel_pos.y <= `OVL_COORD_W'(y);
    endtask

    // one pixel of margin on each side of the window
    task automatic sweep_window(input int sx, input int sy, input int w, input int h);
        int x;
        int y;
        for (y = sy - 1; y <= sy + h; y++) begin
            for (x = sx - 2; x <= sx + w - 1; x++) begin
                drive_pos(x, y);
            end
        end
    endtask

    task automatic random_phase(input int count);
        int n;
        int k;
        for (n = 0; n < count; n++) begin
            if (rand_below(2) == 1) begin       // half aimed at a window
                k = rand_below(4);
                drive_pos(WIN_X[k] - 2 + rand_below(WIN_W[k] + 2),
                          WIN_Y[k] - 1 + rand_below(WIN_H[k] + 2));
            end else begin
                drive_pos(rand_below(2048), rand_below(2048));
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        pixel_pos = '0;
        in_random = 1'b0;
        seed      = 32'hafd51c4f;
        repeat (RESET_CYCLES) @(posedge lcd_pclk);
        rst_n <= 1'b1;
        sweep_window(FREQ_X, LABEL_Y, FREQ_W, LABEL_H);
        sweep_window(VPP_X, LABEL_Y, VPP_W, LABEL_H);
        sweep_window(GLYPH_X, GLYPH0_Y, GLYPH_SIZE, GLYPH_SIZE);
        sweep_window(GLYPH_X, GLYPH1_Y, GLYPH_SIZE, GLYPH_SIZE);
        in_random <= 1'b1;
        random_phase(RANDOM_COUNT);
        in_random <= 1'b0;
        drive_pos(0, 0);
        repeat (2) @(posedge lcd_pclk);         // flush the last pixel
        if (&{freq_seen, vpp_seen, glyph0_seen, glyph1_seen, jump_seen}) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("a window never showed both colours, or no window jump was seen");
        end
    end

endmodule

`default_nettype wire

//--- common/overlay_macros.svh
`ifndef OVERLAY_MACROS_SVH
`define OVERLAY_MACROS_SVH

// ******************************
// widths
// ******************************
`define OVL_COORD_W     11              // pixel x / y counter width
`define OVL_COLOR_W     24              // rgb888

// ******************************
// colours
// ******************************
`define OVL_BACK_COLOR  24'h00ff00      // screen and label background, green
`define OVL_INK_COLOR   24'hffffff      // text ink, white
`define OVL_GLYPH_BACK  24'h000000      // side column background, black

// ******************************
// label row, one line at the bottom
// ******************************
`define OVL_LABEL_Y     446
`define OVL_LABEL_H     16
`define OVL_FREQ_X      10              // frequency label
`define OVL_FREQ_W      48
`define OVL_VPP_X       160             // peak-to-peak label
`define OVL_VPP_W       64

// side column glyphs, square
`define OVL_GLYPH_X     740
`define OVL_GLYPH_SIZE  32
`define OVL_GLYPH0_Y    161
`define OVL_GLYPH1_Y    193

`endif

//--- common/overlay_pkg.sv
`default_nettype none

`include "overlay_macros.svh"

package overlay_pkg;

    // one raster coordinate from the timing generator
    typedef struct packed {
        logic [`OVL_COORD_W-1:0] x;     // column
        logic [`OVL_COORD_W-1:0] y;     // line
    } pix_pos_t;

    // which overlay window a pixel falls into
    typedef enum logic [2:0] {
        none       = 3'd0,
        label_freq = 3'd1,
        label_vpp  = 3'd2,
        glyph_0    = 3'd3,
        glyph_1    = 3'd4
    } region_e;

    // decoded window plus bitmap address inside it
    typedef struct packed {
        region_e    region;
        logic [4:0] row;                // bitmap line, 0..31
        logic [6:0] col;                // bitmap column from the left, 0..63
    } region_hit_t;

endpackage

`default_nettype wire

//--- font/glyph_font_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module glyph_font_rom (
    input  overlay_pkg::region_hit_t hit,
    output logic                     glyph_ink
);

    // ******************************
    // side column glyphs, 32x32
    // ******************************
    localparam logic [`OVL_GLYPH_SIZE-1:0] glyph0_bmp [`OVL_GLYPH_SIZE] = '{
        32'h00000000,               // rows 0..4 blank
        32'h00000000,
        32'h00000000,
        32'h00000000,
        32'h00000000,
        32'h00060070,
        32'h3FFFFFF8,
        32'h180FF070,
        32'h000E7070,
        32'h000E3070,
        32'h080E30F0,
        32'h0C1E30E0,
        32'h061C30E0,
        32'h031C38E0,
        32'h03BC39E0,
        32'h01F819C0,
        32'h00F81DC0,
        32'h00F01DC0,
        32'h00F80F80,
        32'h00FC0F80,
        32'h01DC0F80,
        32'h03DE0F00,
        32'h038F0F80,
        32'h070F1FC0,
        32'h0E073DE0,
        32'h1C0771F0,
        32'h3801E0F8,
        32'h7003C07E,
        32'h40070038,
        32'h001C0000,
        32'h00000000,
        32'h00000000
    };

    localparam logic [`OVL_GLYPH_SIZE-1:0] glyph1_bmp [`OVL_GLYPH_SIZE] = '{
        32'h00000000,
        32'h00000000,
        32'h000000E0,
        32'h1C1FFFF0,
        32'h0E0C01F0,
        32'h0F01C780,
        32'h0700FE00,
        32'h07007C00,
        32'h07183C30,
        32'h001FFFF8,
        32'h001C3878,
        32'h001C3878,
        32'h031C3878,
        32'h7F9FFFF8,
        32'h379C3878,
        32'h079C3878,
        32'h079C3878,
        32'h079C3878,
        32'h079FFFF8,
        32'h079C3878,
        32'h079C3878,
        32'h079C3878,
        32'h079C3878,
        32'h079C3BF8,
        32'h079C3BF0,
        32'h1FD830F0,
        32'h3CF00060,
        32'h787FFFFF,
        32'h701FFFFC,
        32'h0003FFF8,
        32'h00000000,
        32'h00000000
    };

    logic [4:0] glyph_bit;

    assign glyph_bit = 5'(`OVL_GLYPH_SIZE - 1) - hit.col[4:0];   // leftmost pixel is bit 31

    always_comb begin
        case (hit.region)
            overlay_pkg::glyph_0: glyph_ink = glyph0_bmp[hit.row][glyph_bit];
            overlay_pkg::glyph_1: glyph_ink = glyph1_bmp[hit.row][glyph_bit];
            default:              glyph_ink = 1'b0;     // labels and background
        endcase
    end

endmodule

`default_nettype wire

//--- font/label_font_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module label_font_rom (
    input  overlay_pkg::region_hit_t hit,
    output logic                     label_ink
);

    // ******************************
    // label bitmaps, msb is leftmost
    // ******************************
    localparam logic [`OVL_FREQ_W-1:0] freq_bmp [`OVL_LABEL_H] = '{
        48'h100002000000,
        48'h11FE01000000,
        48'h50207FFC0000,
        48'h5C4002000000,
        48'h51FC44440000,
        48'h51042F880000,
        48'hFF2411100000,
        48'h012422480000,
        48'h11244FE40000,
        48'h552400203000,
        48'h552401003000,
        48'h5544FFFE0000,
        48'h845001003000,
        48'h088801003000,
        48'h310401000000,
        48'hC20201000000
    };

    localparam logic [`OVL_VPP_W-1:0] vpp_bmp [`OVL_LABEL_H] = '{
        64'h1040104008400000,
        64'h1040104008400000,
        64'h10FC10FC0FFC0000,
        64'h1088108810400000,
        64'h5550555010400000,
        64'h5420542033F80000,
        64'h54D854D832080000,
        64'h5726572653F80000,
        64'h54F854F892080000,
        64'h5420542013F83000,
        64'h54F854F812083000,
        64'h5C205C2013F80000,
        64'h67FE67FE12083000,
        64'h0020002012083000,
        64'h002000201FFE0000,
        64'h0020002000000000
    };

    logic [5:0] freq_bit;
    logic [5:0] vpp_bit;

    // column 0 maps to the top bit of the row
    assign freq_bit = 6'(`OVL_FREQ_W - 1) - hit.col[5:0];
    assign vpp_bit  = 6'(`OVL_VPP_W - 1) - hit.col[5:0];

    always_comb begin
        case (hit.region)
            overlay_pkg::label_freq: label_ink = freq_bmp[hit.row[3:0]][freq_bit];
            overlay_pkg::label_vpp:  label_ink = vpp_bmp[hit.row[3:0]][vpp_bit];
            default:                 label_ink = 1'b0;  // glyphs and background
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the overlay testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module overlay_tb \
        -Mdir "$BUILD_DIR" -o overlay_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/overlay_sim" > "$LOG" 2>&1; then
    echo "simulation exited with an error status"
fi

cat "$LOG"

if grep -qx "all tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- sources.f
+incdir+common
common/overlay_pkg.sv
font/label_font_rom.sv
font/glyph_font_rom.sv
src/region_decode.sv
src/pixel_color_reg.sv
src/overlay_top.sv
bench/overlay_tb.sv

//--- src/overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module overlay_top (
    input  logic                    lcd_pclk,
    input  logic                    rst_n,
    input  overlay_pkg::pix_pos_t   pixel_pos,
    output logic                    back_en,
    output logic [`OVL_COLOR_W-1:0] pixel_data
);

    overlay_pkg::region_hit_t hit;
    logic                     label_ink;
    logic                     glyph_ink;

    // ******************************
    // decode, same cycle
    // ******************************
    region_decode u_region_decode (
        .pixel_pos (pixel_pos),
        .hit       (hit),
        .back_en   (back_en)
    );

    label_font_rom u_label_font_rom (
        .hit       (hit),
        .label_ink (label_ink)
    );

    glyph_font_rom u_glyph_font_rom (
        .hit       (hit),
        .glyph_ink (glyph_ink)
    );

    // colour out one clock later
    pixel_color_reg u_pixel_color_reg (
        .lcd_pclk   (lcd_pclk),
        .rst_n      (rst_n),
        .region     (hit.region),
        .label_ink  (label_ink),
        .glyph_ink  (glyph_ink),
        .pixel_data (pixel_data)
    );

endmodule

`default_nettype wire

//--- src/pixel_color_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module pixel_color_reg (
    input  logic                    lcd_pclk,
    input  logic                    rst_n,
    input  overlay_pkg::region_e    region,
    input  logic                    label_ink,
    input  logic                    glyph_ink,
    output logic [`OVL_COLOR_W-1:0] pixel_data
);

    logic [`OVL_COLOR_W-1:0] color_nxt;

    // ******************************
    // colour by region class
    // ******************************
    always_comb begin
        case (region)
            overlay_pkg::label_freq,
            overlay_pkg::label_vpp:
                color_nxt = label_ink ? `OVL_INK_COLOR : `OVL_BACK_COLOR;    // white on green
            overlay_pkg::glyph_0,
            overlay_pkg::glyph_1:
                color_nxt = glyph_ink ? `OVL_INK_COLOR : `OVL_GLYPH_BACK;    // white on black
            default:
                color_nxt = `OVL_BACK_COLOR;    // plain screen
        endcase
    end

    // one pixel clock of latency
    always_ff @(posedge lcd_pclk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_data <= `OVL_BACK_COLOR;
        end else begin
            pixel_data <= color_nxt;
        end
    end

    // font tables raise ink only inside their own window class
    a_label_ink_class : assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        label_ink |-> ((region == overlay_pkg::label_freq)
            || (region == overlay_pkg::label_vpp)))
        else $error("label ink set in region %0d", region);

    a_glyph_ink_class : assert property (@(posedge lcd_pclk) disable iff (!rst_n)
        glyph_ink |-> ((region == overlay_pkg::glyph_0)
            || (region == overlay_pkg::glyph_1)))
        else $error("glyph ink set in region %0d", region);

endmodule

`default_nettype wire

//--- src/region_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "overlay_macros.svh"

module region_decode (
    input  overlay_pkg::pix_pos_t    pixel_pos,
    output overlay_pkg::region_hit_t hit,
    output logic                     back_en
);

    logic                    in_label_y;
    logic                    in_glyph_x;
    logic                    in_freq;
    logic                    in_vpp;
    logic                    in_glyph0;
    logic                    in_glyph1;
    logic [3:0]              match;
    logic [`OVL_COORD_W-1:0] freq_col;
    logic [`OVL_COORD_W-1:0] vpp_col;
    logic [`OVL_COORD_W-1:0] glyph_col;
    logic [`OVL_COORD_W-1:0] label_row;
    logic [`OVL_COORD_W-1:0] glyph0_row;
    logic [`OVL_COORD_W-1:0] glyph1_row;

    // ******************************
    // window compare
    // ******************************
    // x windows lead by one pixel and span start-1 .. start+width-2
    assign in_label_y = (pixel_pos.y >= `OVL_COORD_W'(`OVL_LABEL_Y))
                     && (pixel_pos.y <  `OVL_COORD_W'(`OVL_LABEL_Y + `OVL_LABEL_H));

    assign in_glyph_x = (pixel_pos.x >= `OVL_COORD_W'(`OVL_GLYPH_X - 1))
                     && (pixel_pos.x <  `OVL_COORD_W'(`OVL_GLYPH_X + `OVL_GLYPH_SIZE - 1));

    assign in_freq = in_label_y
                  && (pixel_pos.x >= `OVL_COORD_W'(`OVL_FREQ_X - 1))
                  && (pixel_pos.x <  `OVL_COORD_W'(`OVL_FREQ_X + `OVL_FREQ_W - 1));

    assign in_vpp = in_label_y
                 && (pixel_pos.x >= `OVL_COORD_W'(`OVL_VPP_X - 1))
                 && (pixel_pos.x <  `OVL_COORD_W'(`OVL_VPP_X + `OVL_VPP_W - 1));

    assign in_glyph0 = in_glyph_x
                    && (pixel_pos.y >= `OVL_COORD_W'(`OVL_GLYPH0_Y))
                    && (pixel_pos.y <  `OVL_COORD_W'(`OVL_GLYPH0_Y + `OVL_GLYPH_SIZE));

    assign in_glyph1 = in_glyph_x
                    && (pixel_pos.y >= `OVL_COORD_W'(`OVL_GLYPH1_Y))
                    && (pixel_pos.y <  `OVL_COORD_W'(`OVL_GLYPH1_Y + `OVL_GLYPH_SIZE));

    assign match   = {in_glyph1, in_glyph0, in_vpp, in_freq};
    assign back_en = |match;                // any fixed window

    // ******************************
    // bitmap address
    // ******************************
    assign freq_col   = pixel_pos.x + `OVL_COORD_W'(1) - `OVL_COORD_W'(`OVL_FREQ_X);
    assign vpp_col    = pixel_pos.x + `OVL_COORD_W'(1) - `OVL_COORD_W'(`OVL_VPP_X);
    assign glyph_col  = pixel_pos.x + `OVL_COORD_W'(1) - `OVL_COORD_W'(`OVL_GLYPH_X);
    assign label_row  = pixel_pos.y - `OVL_COORD_W'(`OVL_LABEL_Y);
    assign glyph0_row = pixel_pos.y - `OVL_COORD_W'(`OVL_GLYPH0_Y);
    assign glyph1_row = pixel_pos.y - `OVL_COORD_W'(`OVL_GLYPH1_Y);

    always_comb begin
        hit.region = overlay_pkg::none;     // address stays zero outside
        hit.row    = '0;
        hit.col    = '0;
        if (in_freq) begin
            hit.region = overlay_pkg::label_freq;
            hit.row    = 5'(label_row);
            hit.col    = 7'(freq_col);
        end else if (in_vpp) begin
            hit.region = overlay_pkg::label_vpp;
            hit.row    = 5'(label_row);
            hit.col    = 7'(vpp_col);
        end else if (in_glyph0) begin
            hit.region = overlay_pkg::glyph_0;
            hit.row    = 5'(glyph0_row);
            hit.col    = 7'(glyph_col);
        end else if (in_glyph1) begin
            hit.region = overlay_pkg::glyph_1;
            hit.row    = 5'(glyph1_row);
            hit.col    = 7'(glyph_col);
        end
    end

endmodule

`default_nettype wire
